// ==== rtl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int xlen   = 32;
  localparam int reg_aw = 5;

  typedef logic [xlen-1:0]   word_t;
  typedef logic [reg_aw-1:0] reg_addr_t;

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {A_RS1, A_ZERO, A_PC} a_sel_e;
  typedef enum logic {B_RS2, B_IMM} b_sel_e;
  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC_PLUS4} res_sel_e;

  // Register op, immediate op, or plain add for addresses
  typedef enum logic [1:0] {CLS_ADD, CLS_REG, CLS_IMM} alu_class_e;

  // ----------------------------------------------------------
  // Instruction formats
  // ----------------------------------------------------------

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_addr_t   rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    opcode_e    opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  // Decoded control for the instruction in flight
  typedef struct packed {
    logic       reg_write;
    logic       mem_write;
    a_sel_e     a_sel;
    b_sel_e     b_sel;
    alu_class_e alu_class;
    res_sel_e   res_sel;
    logic       is_branch;
    logic       is_jump;
    logic       is_jalr;
    logic [2:0] funct3;
    logic       funct7_b5;
  } ctrl_t;

  localparam word_t instr_nop    = 32'h0000_0013;
  localparam word_t instr_ebreak = 32'h0010_0073;

endpackage

`default_nettype wire

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decoder (
  input  logic              rst_n,
  input  rv_pkg::instr_u    instr,
  output rv_pkg::ctrl_t     ctrl,
  output rv_pkg::word_t     imm,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output logic              ebreak
);
  import rv_pkg::*;

  // Register fields sit at the same place in every format
  assign rs1 = instr.r.rs1;
  assign rs2 = instr.r.rs2;
  assign rd  = instr.r.rd;

  assign ebreak = rst_n && (instr == instr_ebreak);

  always_comb begin
    ctrl.reg_write = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.a_sel     = A_RS1;
    ctrl.b_sel     = B_RS2;
    ctrl.alu_class = CLS_ADD;
    ctrl.res_sel   = RES_ALU;
    ctrl.is_branch = 1'b0;
    ctrl.is_jump   = 1'b0;
    ctrl.is_jalr   = 1'b0;
    ctrl.funct3    = instr.r.funct3;
    ctrl.funct7_b5 = instr.r.funct7[5];
    imm            = '0;

    case (instr.r.opcode)
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_class = CLS_REG;
      end
      OPC_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_sel     = B_IMM;
        ctrl.alu_class = CLS_IMM;
        imm            = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      OPC_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_sel     = B_IMM;
        ctrl.res_sel   = RES_MEM;
        imm            = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.b_sel     = B_IMM;
        imm            = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      end
      OPC_BRANCH: begin
        ctrl.is_branch = 1'b1;
        imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
               instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.res_sel   = RES_PC_PLUS4;
        imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
               instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      OPC_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.b_sel     = B_IMM;
        ctrl.res_sel   = RES_PC_PLUS4;
        imm            = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      OPC_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_sel     = A_ZERO;
        ctrl.b_sel     = B_IMM;
        imm            = {instr.u.imm_31_12, 12'b0};
      end
      OPC_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_sel     = A_PC;
        ctrl.b_sel     = B_IMM;
        imm            = {instr.u.imm_31_12, 12'b0};
      end
      // SYSTEM and unknown words change no state
      default: begin
      end
    endcase

    // Hold off side effects while in reset
    if (!rst_n) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_write = 1'b0;
    end

    assert (!(ctrl.reg_write && ctrl.mem_write))
      else $error("decoder raised reg_write and mem_write together");
  end

endmodule

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::reg_addr_t rd_addr,
  input  logic              rd_en,
  input  rv_pkg::word_t     rd_data,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);
  import rv_pkg::*;

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  a_x0_rs1: assert property (@(posedge clk) rs1_addr == '0 |-> rs1_data == '0);
  a_x0_rs2: assert property (@(posedge clk) rs2_addr == '0 |-> rs2_data == '0);

endmodule

`default_nettype wire

// ==== rtl/rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t pc_plus4,
  input  rv_pkg::word_t mem_rdata,
  output rv_pkg::word_t alu_result,
  output rv_pkg::word_t rd_data
);
  import rv_pkg::*;

  word_t      alu_a;
  word_t      alu_b;
  alu_op_e    alu_op;
  logic [4:0] shamt;

  // ----------------------------------------------------------
  // Operand select
  // ----------------------------------------------------------

  always_comb begin
    case (ctrl.a_sel)
      A_ZERO:  alu_a = '0;
      A_PC:    alu_a = pc;
      default: alu_a = rs1_data;
    endcase
  end

  assign alu_b = (ctrl.b_sel == B_IMM) ? imm : rs2_data;
  assign shamt = alu_b[4:0];

  // ----------------------------------------------------------
  // ALU op decode
  // ----------------------------------------------------------

  always_comb begin
    if (ctrl.alu_class == CLS_ADD) begin
      alu_op = ALU_ADD;
    end else begin
      case (ctrl.funct3)
        // Only register ops subtract since ADDI bit 30 is immediate
        3'b000:  alu_op = (ctrl.alu_class == CLS_REG && ctrl.funct7_b5) ? ALU_SUB : ALU_ADD;
        3'b001:  alu_op = ALU_SLL;
        3'b010:  alu_op = ALU_SLT;
        3'b011:  alu_op = ALU_SLTU;
        3'b100:  alu_op = ALU_XOR;
        3'b101:  alu_op = ctrl.funct7_b5 ? ALU_SRA : ALU_SRL;
        3'b110:  alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
    end
  end

  // ----------------------------------------------------------
  // ALU and write-back select
  // ----------------------------------------------------------

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_result = alu_a + alu_b;
      ALU_SUB:  alu_result = alu_a - alu_b;
      ALU_SLL:  alu_result = alu_a << shamt;
      ALU_SLT:  alu_result = {{(xlen-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU: alu_result = {{(xlen-1){1'b0}}, alu_a < alu_b};
      ALU_XOR:  alu_result = alu_a ^ alu_b;
      ALU_SRL:  alu_result = alu_a >> shamt;
      ALU_SRA:  alu_result = $signed(alu_a) >>> shamt;
      ALU_OR:   alu_result = alu_a | alu_b;
      ALU_AND:  alu_result = alu_a & alu_b;
      default:  alu_result = '0;
    endcase
  end

  always_comb begin
    case (ctrl.res_sel)
      RES_MEM:      rd_data = mem_rdata;
      RES_PC_PLUS4: rd_data = pc_plus4;
      default:      rd_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_fetch #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst_n,
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t alu_result,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4
);
  import rv_pkg::*;

  logic  rs_eq;
  logic  rs_lt_s;
  logic  rs_lt_u;
  logic  branch_taken;
  word_t pc_next;

  assign pc_plus4 = pc + 32'd4;

  // Branch compare
  assign rs_eq   = (rs1_data == rs2_data);
  assign rs_lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign rs_lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.funct3)
      3'b000:  branch_taken = rs_eq;
      3'b001:  branch_taken = !rs_eq;
      3'b100:  branch_taken = rs_lt_s;
      3'b101:  branch_taken = !rs_lt_s;
      3'b110:  branch_taken = rs_lt_u;
      3'b111:  branch_taken = !rs_lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

  // JALR drops the target LSB
  always_comb begin
    if (ctrl.is_jalr) begin
      pc_next = {alu_result[xlen-1:1], 1'b0};
    end else if (ctrl.is_jump || (ctrl.is_branch && branch_taken)) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst_n,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_rdata,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output logic          dmem_we,
  input  rv_pkg::word_t dmem_rdata,
  output logic          ebreak
);
  import rv_pkg::*;

  instr_u    instr;
  ctrl_t     ctrl;
  word_t     pc;
  word_t     pc_plus4;
  word_t     imm;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_result;
  word_t     rd_data;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;

  // ----------------------------------------------------------
  // Memory ports
  // ----------------------------------------------------------

  assign imem_addr  = pc;
  assign instr      = imem_rdata;
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = ctrl.mem_write;

  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .alu_result(alu_result),
    .pc        (pc),
    .pc_plus4  (pc_plus4)
  );

  rv_decoder u_decoder (
    .rst_n (rst_n),
    .instr (instr),
    .ctrl  (ctrl),
    .imm   (imm),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .ebreak(ebreak)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1_addr(rs1),
    .rs2_addr(rs2),
    .rd_addr (rd),
    .rd_en   (ctrl.reg_write),
    .rd_data (rd_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  // Write-back value for the register file
  rv_execute u_execute (
    .ctrl      (ctrl),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .pc        (pc),
    .pc_plus4  (pc_plus4),
    .mem_rdata (dmem_rdata),
    .alu_result(alu_result),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
  end

  always #2 clk = ~clk;

  // Release reset after 8 rising edges
  initial begin
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  localparam word_t reset_pc  = 32'h0000_0000;
  localparam word_t res_base  = 32'h0000_0100;
  localparam int    num_tests = 6;

  logic  clk;
  logic  rst_n;
  word_t imem_addr;
  word_t imem_rdata;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic  dmem_we;
  word_t dmem_rdata;
  logic  ebreak;

  word_t imem [0:255];
  word_t dmem [0:255];
  word_t exp_val [0:63];
  int    slot_grp [0:63];
  logic  slot_bad [0:63];
  logic  slot_seen [0:63];
  int    group_last [0:num_tests-1];
  string test_name [0:num_tests-1];

  int    seed = 32'h6d81;
  int    pidx = 0;
  int    nslot = 0;
  logic  built = 1'b0;
  int    errors = 0;
  int    checks = 0;
  int    tests_passed = 0;
  int    report_grp = -1;
  logic  result_hit;
  int    hit_slot;
  word_t ebreak_pc;

  tb_clock u_clock (.clk(clk), .rst_n(rst_n));

  rv_core #(.RESET_PC(reset_pc)) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_rdata(imem_rdata),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_we   (dmem_we),
    .dmem_rdata(dmem_rdata),
    .ebreak    (ebreak)
  );

  // ----------------------------------------------------------
  // Memory models
  // ----------------------------------------------------------

  // A misaligned fetch returns an illegal all-zero word
  assign imem_rdata = (imem_addr[1:0] == 2'b00) ? imem[imem_addr[9:2]] : '0;
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  assign result_hit = dmem_we && dmem_addr[31:8] == res_base[31:8] && dmem_addr[1:0] == 2'b00;
  assign hit_slot   = int'(dmem_addr[7:2]);

  a_result: assert property (@(posedge clk) disable iff (!rst_n)
    result_hit |-> dmem_wdata == exp_val[hit_slot])
    else begin
      errors++;
      slot_bad[$sampled(hit_slot)] = 1'b1;
      $display("[FAIL] %0t addr %h expected %h got %h",
               $time, $sampled(dmem_addr), exp_val[$sampled(hit_slot)],
               $sampled(dmem_wdata));
    end

  // ----------------------------------------------------------
  // Encoders and reference rules
  // ----------------------------------------------------------

  function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic word_t enc_i(logic [11:0] im, int rs1, logic [2:0] f3, int rd,
                                  logic [6:0] op);
    return {im, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic word_t enc_s(logic [11:0] im, int rs2, int rs1);
    return {im[11:5], 5'(rs2), 5'(rs1), 3'b010, im[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(logic [2:0] f3, int rs1, int rs2, logic [12:0] im);
    return {im[12], im[10:5], 5'(rs2), 5'(rs1), f3, im[4:1], im[11], 7'b1100011};
  endfunction

  function automatic word_t enc_u(logic [6:0] op, int rd, logic [19:0] im);
    return {im, 5'(rd), op};
  endfunction

  function automatic word_t enc_j(int rd, logic [20:0] im);
    return {im[20], im[10:1], im[11], im[19:12], 5'(rd), 7'b1101111};
  endfunction

  function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_rule(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Program builder
  // ----------------------------------------------------------

  task automatic emit(word_t w);
    imem[pidx] = w;
    pidx++;
  endtask

  function automatic word_t here();
    return reset_pc + 4 * pidx;
  endfunction

  task automatic load_const(int rd, word_t val);
    word_t upper;
    upper = (val + 32'h800) >> 12;
    emit(enc_u(7'b0110111, rd, upper[19:0]));
    emit(enc_i(val[11:0], rd, 3'b000, rd, 7'b0010011));
  endtask

  task automatic store_result(int rs, word_t val, int test);
    word_t addr;
    addr = res_base + 4 * nslot;
    emit(enc_s(addr[11:0], rs, 0));
    exp_val[nslot]    = val;
    slot_grp[nslot]   = test;
    group_last[test]  = nslot;
    nslot++;
  endtask

  task automatic build_program();
    word_t       a;
    word_t       b;
    word_t       lo;
    word_t       hi;
    word_t       pc0;
    logic [11:0] im;
    logic [19:0] u;
    logic [2:0]  f3s [0:5];
    logic        tk;
    f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    // Register and immediate ALU ops
    a = $random(seed);
    b = $random(seed);
    load_const(1, a);
    load_const(2, b);
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, 2, 1, 3'(f), 3));
      store_result(3, alu_model(3'(f), 1'b0, a, b), 0);
      if (f == 0 || f == 5) begin
        emit(enc_r(7'h20, 2, 1, 3'(f), 3));
        store_result(3, alu_model(3'(f), 1'b1, a, b), 0);
      end
    end
    for (int f = 0; f < 8; f++) begin
      im = (f == 1 || f == 5) ? {7'h00, b[4:0]} : a[31:20] ^ b[11:0] ^ 12'(f);
      emit(enc_i(im, 1, 3'(f), 3, 7'b0010011));
      store_result(3, alu_model(3'(f), 1'b0, a, {{20{im[11]}}, im}), 0);
    end
    emit(enc_i({7'h20, b[9:5]}, 1, 3'b101, 3, 7'b0010011));
    store_result(3, alu_model(3'b101, 1'b1, a, {27'b0, b[9:5]}), 0);

    // LUI and AUIPC
    u = $random(seed);
    emit(enc_u(7'b0110111, 4, u));
    store_result(4, {u, 12'b0}, 1);
    pc0 = here();
    emit(enc_u(7'b0010111, 5, u));
    store_result(5, pc0 + {u, 12'b0}, 1);

    // Word store and load round trip through a scratch address
    a = $random(seed);
    load_const(6, a);
    emit(enc_s(12'h080, 6, 0));
    emit(enc_i(12'h080, 0, 3'b010, 7, 7'b0000011));
    store_result(7, a, 2);

    // Branches, each taken and not taken
    for (int k = 0; k < 12; k++) begin
      a = $random(seed);
      b = $random(seed);
      if (a == b) begin
        b = a + 1;
      end
      if (k / 2 < 4) begin
        lo = ($signed(a) < $signed(b)) ? a : b;
        hi = ($signed(a) < $signed(b)) ? b : a;
      end else begin
        lo = (a < b) ? a : b;
        hi = (a < b) ? b : a;
      end
      case (k / 2)
        0: begin
          a = lo;
          b = (k % 2 == 0) ? lo : hi;
        end
        1: begin
          a = lo;
          b = (k % 2 == 0) ? hi : lo;
        end
        2, 4: begin
          a = (k % 2 == 0) ? lo : hi;
          b = (k % 2 == 0) ? hi : lo;
        end
        default: begin
          a = (k % 2 == 0) ? hi : lo;
          b = (k % 2 == 0) ? lo : hi;
        end
      endcase
      tk = branch_rule(f3s[k/2], a, b);
      load_const(1, a);
      load_const(2, b);
      emit(enc_i(12'h000, 0, 3'b000, 8, 7'b0010011));
      emit(enc_b(f3s[k/2], 1, 2, 13'd8));
      emit(enc_i(12'h001, 0, 3'b000, 8, 7'b0010011));
      store_result(8, tk ? 32'd0 : 32'd1, 3);
    end

    // JAL over two instructions, then JALR with the base LSB set
    pc0 = here();
    emit(enc_j(9, 21'd12));
    emit(enc_i(12'h011, 0, 3'b000, 9, 7'b0010011));
    emit(enc_i(12'h022, 0, 3'b000, 9, 7'b0010011));
    store_result(9, pc0 + 4, 4);
    emit(enc_i(12'h000, 0, 3'b000, 14, 7'b0010011));
    load_const(11, here() + 8 + 12 + 1);
    pc0 = here();
    emit(enc_i(12'h000, 11, 3'b000, 12, 7'b1100111));
    emit(enc_i(12'h011, 0, 3'b000, 14, 7'b0010011));
    emit(enc_i(12'h022, 0, 3'b000, 14, 7'b0010011));
    emit(enc_i(12'h7a, 14, 3'b000, 14, 7'b0010011));
    store_result(14, 32'h7a, 4);
    store_result(12, pc0 + 4, 4);

    // Writes to x0 are dropped
    emit(enc_i(12'h05a, 0, 3'b000, 0, 7'b0010011));
    store_result(0, 32'd0, 5);
    ebreak_pc = here();
    emit(instr_ebreak);
  endtask

  initial begin
    test_name = '{"alu ops", "lui auipc", "load store", "branches", "jumps", "x0 write"};
    for (int i = 0; i < 256; i++) begin
      imem[i] = instr_nop;
      dmem[i] = (32'(i) * 32'h9e37_79b9) ^ {24'h5a5a5a, 8'(i)};
    end
    for (int i = 0; i < 64; i++) begin
      exp_val[i]   = '0;
      slot_grp[i]  = -1;
      slot_bad[i]  = 1'b0;
      slot_seen[i] = 1'b0;
    end
    build_program();
    built = 1'b1;
  end

  // ----------------------------------------------------------
  // Reporting
  // ----------------------------------------------------------

  task automatic report_group(int g);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < nslot; i++) begin
      if (slot_grp[i] == g && (slot_bad[i] || !slot_seen[i])) begin
        ok = 1'b0;
      end
    end
    if (ok) begin
      tests_passed++;
    end
    $display("test %0d %s: %s", g, test_name[g], ok ? "pass" : "fail");
  endtask

  // Group lines print one edge late so the assertion has settled
  always @(posedge clk) begin
    if (report_grp >= 0) begin
      report_group(report_grp);
      report_grp = -1;
    end
    if (rst_n && result_hit) begin
      checks++;
      slot_seen[hit_slot] = 1'b1;
      if (slot_grp[hit_slot] >= 0 && hit_slot == group_last[slot_grp[hit_slot]]) begin
        report_grp = slot_grp[hit_slot];
      end
    end
    if (rst_n && ebreak) begin
      checks++;
      assert (imem_addr == ebreak_pc)
        else begin
          errors++;
          $display("[FAIL] %0t ebreak at %h expected %h", $time, imem_addr, ebreak_pc);
        end
      for (int i = 0; i < nslot; i++) begin
        if (!slot_seen[i]) begin
          errors++;
          $display("result address %h was never written", res_base + 4 * i);
        end
      end
      $display("tests passed %0d of %0d, checks %0d, errors %0d",
               tests_passed, num_tests, checks, errors);
      if (errors == 0 && tests_passed == num_tests) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

  // Watchdog scaled to program length
  initial begin
    wait (built);
    repeat (pidx * 2 + 100) @(posedge clk);
    $display("timeout: the core never reached EBREAK");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_fetch.sv
rtl/rv_core.sv
tests/tb_clock.sv
tests/tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module tb_rv_core -f src.f -o sim_rv_core

out=$(./obj_dir/sim_rv_core)
echo "$out"

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
else
  exit 1
fi
